//--- tmpSense_defines.svh
`ifndef TMP_SENSE_DEFINES_SVH
`define TMP_SENSE_DEFINES_SVH

// datapath widths
`define TMP_COUNT_W 8
`define TMP_SAMPLE_W 9
`define TMP_CYCLE_W 8
`define TMP_ROUND_W 6

// mode sequencer timing, in clk cycles
`define TMP_PRECHARGE_CYCLES 15
`define TMP_SLEEP_CYCLES 12
`define TMP_CONV_WINDOW 226

// phase lengths within one round
`define TMP_DIODE_CYCLES 6
`define TMP_BIGDIODE_MIN 10
`define TMP_BIGDIODE_MAX 21
`define TMP_CHARGE_CYCLES 6
`define TMP_OUTPUT_CYCLES 5

// round tallies
`define TMP_BG_ROUNDS 12
// flip accepted only after this many PTAT rounds
`define TMP_PTAT_MIN_ROUNDS 7

`endif

//--- tmpSeqPkg.sv
`default_nettype none

package tmpSeqPkg;

    // top-level measurement modes
    typedef enum logic [2:0] {
        PRECHARGE,
        BANDGAP,
        PTAT,
        CONVERT,
        SLEEP
    } modeState_t;

    // phases of one calibration round
    typedef enum logic [2:0] {
        IDLE,
        BLANKBIG,
        BIGDIODE,
        BLANKDIODE,
        DIODE,
        HCHARGE,
        LCHARGE,
        OUTPUT
    } phaseState_t;

endpackage

`default_nettype wire

//--- tmpMeasPkg.sv
`default_nettype none

`include "tmpSense_defines.svh"

package tmpMeasPkg;

    // one conversion result
    typedef logic [`TMP_COUNT_W-1:0] tmpCount_t;

    // conversion window timer
    typedef logic [`TMP_SAMPLE_W-1:0] sampleCount_t;

    // phase, precharge and sleep timers
    typedef logic [`TMP_CYCLE_W-1:0] cycleCount_t;

    // round tally
    typedef logic [`TMP_ROUND_W-1:0] roundCount_t;

endpackage

`default_nettype wire

//--- tmpPhaseSeq.sv
`timescale 1ns/10ps
`default_nettype none

`include "tmpSense_defines.svh"

module tmpPhaseSeq (
    input wire clk,
    input wire reset,
    input wire cmpSync,
    input wire roundStart,
    input wire tmpSeqPkg::modeState_t roundMode,
    output logic roundDone,
    output logic pI1,
    output logic pI2,
    output logic pII1,
    output logic pII2,
    output logic pA,
    output logic pB,
    output logic pC,
    output logic pD,
    output logic srcN,
    output logic snk,
    output logic cmpP1,
    output logic cmpP2
);

    localparam tmpMeasPkg::cycleCount_t diodeLast = `TMP_DIODE_CYCLES - 1;
    localparam tmpMeasPkg::cycleCount_t bigMinLast = `TMP_BIGDIODE_MIN - 1;
    localparam tmpMeasPkg::cycleCount_t bigMaxLast = `TMP_BIGDIODE_MAX - 1;
    localparam tmpMeasPkg::cycleCount_t chargeLast = `TMP_CHARGE_CYCLES - 1;
    localparam tmpMeasPkg::cycleCount_t outputLast = `TMP_OUTPUT_CYCLES - 1;

    tmpSeqPkg::phaseState_t phaseState;
    tmpMeasPkg::cycleCount_t timer;
    logic heldCmp;
    logic hDone;
    logic chop;
    logic bigEnd;
    logic prechargeIdle;

    // comparator change ends big diode early, but only after the minimum
    assign bigEnd = ((timer >= bigMinLast) && (cmpSync != heldCmp)) || (timer == bigMaxLast);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phaseState <= tmpSeqPkg::IDLE;
            timer <= '0;
            heldCmp <= 1'b0;
            hDone <= 1'b0;
            chop <= 1'b0;
            roundDone <= 1'b0;
        end else begin
            roundDone <= 1'b0;
            case (phaseState)
                tmpSeqPkg::IDLE: begin
                    if (roundStart) begin
                        hDone <= 1'b0;
                        phaseState <= tmpSeqPkg::BLANKBIG;
                    end
                end
                tmpSeqPkg::BLANKBIG: begin
                    timer <= '0;
                    heldCmp <= cmpSync;
                    phaseState <= tmpSeqPkg::BIGDIODE;
                end
                tmpSeqPkg::BIGDIODE: begin
                    if (bigEnd) begin
                        timer <= '0;
                        phaseState <= tmpSeqPkg::BLANKDIODE;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                tmpSeqPkg::BLANKDIODE: begin
                    timer <= '0;
                    phaseState <= tmpSeqPkg::DIODE;
                end
                tmpSeqPkg::DIODE: begin
                    if (timer == diodeLast) begin
                        timer <= '0;
                        chop <= ~chop;
                        // PTAT rounds stop here
                        if (roundMode == tmpSeqPkg::PTAT) begin
                            roundDone <= 1'b1;
                            phaseState <= tmpSeqPkg::IDLE;
                        end else if (hDone) begin
                            phaseState <= tmpSeqPkg::LCHARGE;
                        end else begin
                            phaseState <= tmpSeqPkg::HCHARGE;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                tmpSeqPkg::HCHARGE: begin
                    if (timer == chargeLast) begin
                        timer <= '0;
                        hDone <= 1'b1;
                        phaseState <= tmpSeqPkg::BLANKBIG;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                tmpSeqPkg::LCHARGE: begin
                    if (timer == chargeLast) begin
                        timer <= '0;
                        phaseState <= tmpSeqPkg::OUTPUT;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                tmpSeqPkg::OUTPUT: begin
                    if (timer == outputLast) begin
                        timer <= '0;
                        roundDone <= 1'b1;
                        phaseState <= tmpSeqPkg::IDLE;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: begin
                    phaseState <= tmpSeqPkg::IDLE;
                end
            endcase
        end
    end

    // front end is held precharged while no round runs
    assign prechargeIdle = (phaseState == tmpSeqPkg::IDLE) && (roundMode == tmpSeqPkg::PRECHARGE);

    assign pI1 = (phaseState == tmpSeqPkg::BLANKBIG) || (phaseState == tmpSeqPkg::BIGDIODE);
    assign pI2 = (phaseState == tmpSeqPkg::BIGDIODE);
    assign pII1 = (phaseState == tmpSeqPkg::BLANKDIODE) || (phaseState == tmpSeqPkg::DIODE);
    assign pII2 = (phaseState == tmpSeqPkg::DIODE);
    assign pA = (phaseState == tmpSeqPkg::HCHARGE) || (phaseState == tmpSeqPkg::LCHARGE);
    assign pB = (phaseState == tmpSeqPkg::HCHARGE) || (phaseState == tmpSeqPkg::OUTPUT)
        || prechargeIdle;
    assign pC = (phaseState == tmpSeqPkg::LCHARGE) || (phaseState == tmpSeqPkg::OUTPUT)
        || prechargeIdle;
    assign pD = (phaseState == tmpSeqPkg::OUTPUT) || prechargeIdle;
    assign srcN = pI2 && cmpSync;
    assign snk = pI2 && !cmpSync;
    assign cmpP1 = chop;
    assign cmpP2 = ~chop;

endmodule

`default_nettype wire

//--- tmpModeCtrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "tmpSense_defines.svh"

module tmpModeCtrl (
    input wire clk,
    input wire reset,
    input wire cmpSync,
    input wire roundDone,
    input wire windowDone,
    input wire countsReady,
    output logic roundStart,
    output tmpSeqPkg::modeState_t roundMode,
    output logic convActive,
    output logic countSelect,
    output logic countClear,
    output logic sBg2Cmp,
    output logic sBgCtrl,
    output logic sPtatCtrl,
    output logic sCap2Cmp,
    output logic sRef2Cmp,
    output logic sCapRst,
    output logic sPtatOut,
    output logic sRdisconN,
    output logic pwrUp,
    output logic preChrg,
    output logic valid
);

    localparam tmpMeasPkg::cycleCount_t prechargeLast = `TMP_PRECHARGE_CYCLES - 1;
    localparam tmpMeasPkg::cycleCount_t sleepLast = `TMP_SLEEP_CYCLES - 1;
    localparam tmpMeasPkg::roundCount_t bgLast = `TMP_BG_ROUNDS - 1;
    localparam tmpMeasPkg::roundCount_t ptatMinLast = `TMP_PTAT_MIN_ROUNDS - 1;

    tmpSeqPkg::modeState_t modeState;
    tmpMeasPkg::cycleCount_t timer;
    tmpMeasPkg::roundCount_t roundCount;
    logic started;
    logic wokeOnce;
    logic roundBusy;
    logic lastPtatCmp;
    logic wakeNow;
    logic inRoundMode;

    assign inRoundMode = (modeState == tmpSeqPkg::BANDGAP) || (modeState == tmpSeqPkg::PTAT);
    assign wakeNow = (modeState == tmpSeqPkg::SLEEP) && started && !wokeOnce
        && (timer == sleepLast);

    // comes out of reset asleep, one idle cycle before precharge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            modeState <= tmpSeqPkg::SLEEP;
            timer <= '0;
            roundCount <= '0;
            started <= 1'b0;
            wokeOnce <= 1'b0;
            roundBusy <= 1'b0;
            roundStart <= 1'b0;
            lastPtatCmp <= 1'b0;
            valid <= 1'b0;
        end else begin
            roundStart <= 1'b0;
            valid <= 1'b0;
            if (inRoundMode && !roundBusy) begin
                roundStart <= 1'b1;
                roundBusy <= 1'b1;
            end
            if (roundDone) begin
                roundBusy <= 1'b0;
            end
            case (modeState)
                tmpSeqPkg::PRECHARGE: begin
                    if (timer == prechargeLast) begin
                        timer <= '0;
                        modeState <= tmpSeqPkg::BANDGAP;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                tmpSeqPkg::BANDGAP: begin
                    if (roundDone) begin
                        if (roundCount == bgLast) begin
                            roundCount <= '0;
                            modeState <= tmpSeqPkg::PTAT;
                        end else begin
                            roundCount <= roundCount + 1'b1;
                        end
                    end
                end
                tmpSeqPkg::PTAT: begin
                    if (roundDone) begin
                        // flip polarity picks the counter for this window
                        if ((roundCount >= ptatMinLast) && (cmpSync != lastPtatCmp)) begin
                            lastPtatCmp <= cmpSync;
                            roundCount <= '0;
                            modeState <= tmpSeqPkg::CONVERT;
                        end else if (roundCount < ptatMinLast) begin
                            roundCount <= roundCount + 1'b1;
                        end
                    end
                end
                tmpSeqPkg::CONVERT: begin
                    if (windowDone) begin
                        if (countsReady) begin
                            valid <= 1'b1;
                            timer <= '0;
                            modeState <= tmpSeqPkg::SLEEP;
                        end else begin
                            modeState <= tmpSeqPkg::PTAT;
                        end
                    end
                end
                tmpSeqPkg::SLEEP: begin
                    if (!started) begin
                        started <= 1'b1;
                        timer <= '0;
                        modeState <= tmpSeqPkg::PRECHARGE;
                    end else if (wakeNow) begin
                        wokeOnce <= 1'b1;
                        timer <= '0;
                        modeState <= tmpSeqPkg::BANDGAP;
                    end else if (!wokeOnce) begin
                        timer <= timer + 1'b1;
                    end
                end
                default: begin
                    modeState <= tmpSeqPkg::SLEEP;
                end
            endcase
        end
    end

    assign roundMode = modeState;
    assign convActive = (modeState == tmpSeqPkg::CONVERT);
    assign countSelect = lastPtatCmp;
    // counters are clear by the time pwrUp rises again
    assign countClear = wakeNow;

    assign pwrUp = (modeState != tmpSeqPkg::SLEEP);
    assign preChrg = (modeState == tmpSeqPkg::PRECHARGE);
    assign sBgCtrl = (modeState == tmpSeqPkg::PRECHARGE) || (modeState == tmpSeqPkg::BANDGAP);
    assign sRdisconN = (modeState == tmpSeqPkg::PRECHARGE) || (modeState == tmpSeqPkg::BANDGAP);
    assign sPtatCtrl = (modeState == tmpSeqPkg::PRECHARGE) || (modeState == tmpSeqPkg::PTAT)
        || convActive;
    assign sBg2Cmp = inRoundMode;
    assign sCap2Cmp = convActive;
    assign sRef2Cmp = convActive;
    assign sPtatOut = convActive;
    assign sCapRst = started && !convActive;

endmodule

`default_nettype wire

//--- tmpConvCounter.sv
`timescale 1ns/10ps
`default_nettype none

`include "tmpSense_defines.svh"

module tmpConvCounter (
    input wire clk,
    input wire reset,
    input wire cmp,
    input wire convActive,
    input wire countSelect,
    input wire countClear,
    output logic cmpSync,
    output logic windowDone,
    output logic countsReady,
    output logic sCcoCap1,
    output logic sCcoCap2,
    output tmpMeasPkg::tmpCount_t tmpCount1,
    output tmpMeasPkg::tmpCount_t tmpCount2
);

    localparam tmpMeasPkg::sampleCount_t windowLast = `TMP_CONV_WINDOW - 1;

    tmpMeasPkg::sampleCount_t sampleCount;
    logic cmpMeta;
    logic cmpDly;
    logic cmpRise;
    logic capSel;

    // two-flop synchronizer, then one more stage for the edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmpMeta <= 1'b0;
            cmpSync <= 1'b0;
            cmpDly <= 1'b0;
        end else begin
            cmpMeta <= cmp;
            cmpSync <= cmpMeta;
            cmpDly <= cmpSync;
        end
    end

    assign cmpRise = cmpSync && !cmpDly;
    assign windowDone = convActive && (sampleCount == windowLast);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sampleCount <= '0;
            capSel <= 1'b0;
            tmpCount1 <= '0;
            tmpCount2 <= '0;
        end else begin
            if (!convActive || windowDone) begin
                sampleCount <= '0;
            end else begin
                sampleCount <= sampleCount + 1'b1;
            end
            if (countClear) begin
                tmpCount1 <= '0;
                tmpCount2 <= '0;
            end else if (convActive && cmpRise) begin
                // chop the oscillator caps on every counted edge
                capSel <= ~capSel;
                if (countSelect) begin
                    tmpCount1 <= tmpCount1 + 1'b1;
                end else begin
                    tmpCount2 <= tmpCount2 + 1'b1;
                end
            end
        end
    end

    assign sCcoCap1 = capSel;
    assign sCcoCap2 = ~capSel;
    assign countsReady = (tmpCount1 != '0) && (tmpCount2 != '0);

endmodule

`default_nettype wire

//--- tmpDig.sv
`timescale 1ns/10ps
`default_nettype none

module tmpDig (
    input wire clk,
    input wire reset,
    input wire cmp,
    output logic pI1, pI2, pII1, pII2,
    output logic pA, pB, pC, pD,
    output logic sBg2Cmp, sBgCtrl, sPtatCtrl, sCap2Cmp, sRef2Cmp,
    output logic sCapRst, sPtatOut, sRdisconN, sCcoCap1, sCcoCap2,
    output logic srcN, snk, cmpP1, cmpP2,
    output logic pwrUp, preChrg, valid,
    output tmpMeasPkg::tmpCount_t tmpCount1,
    output tmpMeasPkg::tmpCount_t tmpCount2
);

    logic cmpSync;
    logic roundStart;
    logic roundDone;
    tmpSeqPkg::modeState_t roundMode;
    logic convActive;
    logic countSelect;
    logic countClear;
    logic windowDone;
    logic countsReady;

    tmpModeCtrl uModeCtrl (
        .clk, .reset, .cmpSync,
        .roundDone, .windowDone, .countsReady,
        .roundStart, .roundMode,
        .convActive, .countSelect, .countClear,
        .sBg2Cmp, .sBgCtrl, .sPtatCtrl, .sCap2Cmp, .sRef2Cmp,
        .sCapRst, .sPtatOut, .sRdisconN,
        .pwrUp, .preChrg, .valid
    );

    tmpPhaseSeq uPhaseSeq (
        .clk, .reset, .cmpSync,
        .roundStart, .roundMode, .roundDone,
        .pI1, .pI2, .pII1, .pII2,
        .pA, .pB, .pC, .pD,
        .srcN, .snk, .cmpP1, .cmpP2
    );

    tmpConvCounter uConvCounter (
        .clk, .reset, .cmp,
        .convActive, .countSelect, .countClear,
        .cmpSync, .windowDone, .countsReady,
        .sCcoCap1, .sCcoCap2,
        .tmpCount1, .tmpCount2
    );

endmodule

`default_nettype wire

//--- tmpDigTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "tmpSense_defines.svh"

module tmpDigTb;

    localparam int clkPeriod = 40;
    localparam int resetCycles = 5;
    localparam int leadCycles = 8;
    localparam int pulseHalf = 4;
    localparam int tailMargin = 12;
    localparam int maxPulses = (`TMP_CONV_WINDOW - leadCycles - tailMargin) / (2 * pulseHalf);
    localparam int tailCycles = 3 * `TMP_SLEEP_CYCLES;

    // worst-case lengths in clk cycles
    localparam int bgRoundMax = 2 * (2 + `TMP_BIGDIODE_MAX + `TMP_DIODE_CYCLES)
        + 2 * `TMP_CHARGE_CYCLES + `TMP_OUTPUT_CYCLES + 4;
    localparam int ptatRoundMax = 2 + `TMP_BIGDIODE_MAX + `TMP_DIODE_CYCLES + 4;
    localparam int windowMax = (`TMP_PTAT_MIN_ROUNDS + 2) * ptatRoundMax + `TMP_CONV_WINDOW + 4;
    localparam int measureMax = `TMP_PRECHARGE_CYCLES + `TMP_BG_ROUNDS * bgRoundMax
        + 2 * windowMax + `TMP_SLEEP_CYCLES + 8;
    localparam int watchdogCycles = 2 * (2 * measureMax);

    localparam tmpMeasPkg::cycleCount_t prechargeLen = `TMP_PRECHARGE_CYCLES;
    localparam tmpMeasPkg::cycleCount_t sleepLen = `TMP_SLEEP_CYCLES;
    localparam tmpMeasPkg::cycleCount_t bgRounds = `TMP_BG_ROUNDS;

    logic clk;
    logic reset;
    logic cmp;
    logic pI1, pI2, pII1, pII2;
    logic pA, pB, pC, pD;
    logic sBg2Cmp, sBgCtrl, sPtatCtrl, sCap2Cmp, sRef2Cmp;
    logic sCapRst, sPtatOut, sRdisconN, sCcoCap1, sCcoCap2;
    logic srcN, snk, cmpP1, cmpP2;
    logic pwrUp, preChrg, valid;
    tmpMeasPkg::tmpCount_t tmpCount1;
    tmpMeasPkg::tmpCount_t tmpCount2;

    integer seed;
    // pulses driven per window and the flip polarity that opened it
    int winPulses[$];
    logic winPolarity[$];
    int firstWin;
    int validCount;
    int tailCount;
    int checksRun;
    int mismatchCount;
    int failureCount;
    logic resetTail;
    logic prevPreChrg;
    logic prevPd;
    logic prevPtatCtrl;
    logic prevPwrUp;
    tmpMeasPkg::cycleCount_t preCycles;
    tmpMeasPkg::cycleCount_t sleepCycles;
    tmpMeasPkg::cycleCount_t pdRises;

    tmpDig DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic checkBit(input logic actual, input logic expected, input string what);
        checksRun++;
        if (actual !== expected) begin
            mismatchCount++;
            $display("Mismatch at %0d ns: %s, expected %b, got %b",
                $time, what, expected, actual);
        end
    endtask

    task automatic checkCount(input tmpMeasPkg::tmpCount_t actual,
            input tmpMeasPkg::tmpCount_t expected, input string what);
        checksRun++;
        if (actual !== expected) begin
            mismatchCount++;
            $display("Mismatch at %0d ns: %s, expected %0d, got %0d",
                $time, what, expected, actual);
        end
    endtask

    task automatic checkCycles(input tmpMeasPkg::cycleCount_t actual,
            input tmpMeasPkg::cycleCount_t expected, input string what);
        checksRun++;
        if (actual !== expected) begin
            mismatchCount++;
            $display("Mismatch at %0d ns: %s, expected %0d, got %0d",
                $time, what, expected, actual);
        end
    endtask

    task automatic flagFailure(input string what);
        failureCount++;
        $display("Error at %0d ns: %s", $time, what);
    endtask

    // expected counter pair over the windows of one measurement
    function automatic void expectCounts(input int fromWin,
            output tmpMeasPkg::tmpCount_t exp1, output tmpMeasPkg::tmpCount_t exp2);
        exp1 = '0;
        exp2 = '0;
        for (int i = fromWin; i < winPulses.size(); i++) begin
            // a flip to 1 feeds counter 1, a flip to 0 feeds counter 2
            if (winPolarity[i]) begin
                exp1 = exp1 + tmpMeasPkg::tmpCount_t'(winPulses[i]);
            end else begin
                exp2 = exp2 + tmpMeasPkg::tmpCount_t'(winPulses[i]);
            end
        end
    endfunction

    task automatic inspectResetOutputs();
        checkBit(|{pI1, pI2, pII1, pII2}, 1'b0, "diode switches in reset");
        checkBit(|{pA, pB, pC, pD}, 1'b0, "charge switches in reset");
        checkBit(|{sBg2Cmp, sBgCtrl, sPtatCtrl, sCap2Cmp, sRef2Cmp}, 1'b0,
            "bandgap and PTAT switches in reset");
        checkBit(|{sCapRst, sPtatOut, sRdisconN, sCcoCap1}, 1'b0, "cap switches in reset");
        checkBit(|{srcN, snk, cmpP1}, 1'b0, "current steering in reset");
        checkBit(|{pwrUp, preChrg, valid}, 1'b0, "pwrUp, preChrg and valid in reset");
        checkBit(sCcoCap2 && cmpP2, 1'b1, "sCcoCap2 and cmpP2 in reset");
        checkCount(tmpCount1, '0, "tmpCount1 in reset");
        checkCount(tmpCount2, '0, "tmpCount2 in reset");
    endtask

    task automatic sampleOutputs();
        tmpMeasPkg::tmpCount_t exp1;
        tmpMeasPkg::tmpCount_t exp2;
        // reset values hold for one cycle past release
        if (reset || resetTail) begin
            inspectResetOutputs();
            resetTail = reset;
        end

        checkBit(pI2 && pII2, 1'b0, "pI2 and pII2 both high");
        checkBit(srcN && snk, 1'b0, "srcN and snk both high");
        checkBit(cmpP2, ~cmpP1, "cmpP2 against cmpP1");
        checkBit(sCcoCap2, ~sCcoCap1, "sCcoCap2 against sCcoCap1");

        if (preChrg) begin
            preCycles = preCycles + 1'b1;
            checkBit(pwrUp, 1'b1, "pwrUp during precharge");
            checkBit(pB && pC && pD, 1'b1, "pB, pC and pD during precharge");
            checkBit(sBgCtrl && sPtatCtrl, 1'b1, "sBgCtrl and sPtatCtrl during precharge");
        end else if (prevPreChrg) begin
            checkCycles(preCycles, prechargeLen, "precharge length");
        end

        // one output phase per bandgap round
        if (pD && !prevPd && !preChrg) begin
            pdRises = pdRises + 1'b1;
        end
        if (sPtatCtrl && !prevPtatCtrl && !preChrg) begin
            checkCycles(pdRises, bgRounds, "bandgap rounds before PTAT");
            pdRises = '0;
        end

        if (valid) begin
            validCount++;
            if (validCount > 2) begin
                flagFailure("a third valid pulse appeared");
            end
            checkBit(prevPwrUp && !pwrUp, 1'b1, "pwrUp falling with valid");
            expectCounts(firstWin, exp1, exp2);
            checkCount(tmpCount1, exp1, "tmpCount1 at valid");
            checkCount(tmpCount2, exp2, "tmpCount2 at valid");
            firstWin = winPulses.size();
            sleepCycles = '0;
        end

        if (validCount == 1) begin
            if (!pwrUp) begin
                sleepCycles = sleepCycles + 1'b1;
            end else if (!prevPwrUp) begin
                checkCycles(sleepCycles, sleepLen, "sleep length before wake-up");
                checkCount(tmpCount1, '0, "tmpCount1 after wake-up");
                checkCount(tmpCount2, '0, "tmpCount2 after wake-up");
            end
        end else if (validCount >= 2) begin
            checkBit(pwrUp, 1'b0, "pwrUp after the final measurement");
            tailCount++;
        end

        prevPreChrg = preChrg;
        prevPd = pD;
        prevPtatCtrl = sPtatCtrl;
        prevPwrUp = pwrUp;
    endtask

    task automatic waitWindowStart();
        @(negedge clk);
        while (!sCapRst) @(negedge clk);
        while (sCapRst) @(negedge clk);
    endtask

    // cmp low first, then pulses 4 high and 4 low
    task automatic driveWindow(input int pulses);
        @(posedge clk);
        cmp <= 1'b0;
        repeat (leadCycles - 1) @(posedge clk);
        for (int i = 0; i < pulses; i++) begin
            cmp <= 1'b1;
            repeat (pulseHalf) @(posedge clk);
            cmp <= 1'b0;
            repeat (pulseHalf) @(posedge clk);
        end
    endtask

    initial begin
        int n;
        reset = 1'b1;
        cmp = 1'b0;
        seed = 49875;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        for (int meas = 0; meas < 2; meas++) begin
            // start of the PTAT search
            @(negedge clk);
            while (!(sPtatCtrl && !sBgCtrl && sCapRst)) @(negedge clk);
            @(posedge clk);
            cmp <= 1'b1;
            // first window only feeds counter 1, the second flip goes to 0
            for (int win = 0; win < 2; win++) begin
                waitWindowStart();
                n = 1 + int'({$random(seed)} % maxPulses);
                winPulses.push_back(n);
                winPolarity.push_back(cmp);
                driveWindow(n);
            end
        end
    end

    initial begin
        firstWin = 0;
        validCount = 0;
        tailCount = 0;
        checksRun = 0;
        mismatchCount = 0;
        failureCount = 0;
        resetTail = 1'b0;
        prevPreChrg = 1'b0;
        prevPd = 1'b0;
        prevPtatCtrl = 1'b0;
        prevPwrUp = 1'b0;
        preCycles = '0;
        sleepCycles = '0;
        pdRises = '0;
        while (tailCount < tailCycles) begin
            @(negedge clk);
            sampleOutputs();
        end
        checkCycles(preCycles, prechargeLen, "precharge cycles over the whole run");
        $display("checks run: %0d, mismatches: %0d, other errors: %0d",
            checksRun, mismatchCount, failureCount);
        if ((mismatchCount == 0) && (failureCount == 0)) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Timeout: the run did not end within %0d clock cycles", watchdogCycles);
        $display("checks run: %0d, mismatches: %0d, other errors: %0d",
            checksRun, mismatchCount, failureCount);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- tmpSense.f
+incdir+.
tmpSeqPkg.sv
tmpMeasPkg.sv
tmpPhaseSeq.sv
tmpModeCtrl.sv
tmpConvCounter.sv
tmpDig.sv
tmpDigTb.sv

//--- runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tmpDigTb -f tmpSense.f
out=$(./obj_dir/VtmpDigTb)
echo "$out"

if echo "$out" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1
